//--- FetchFrontEnd.f
src/RvTypes.sv
src/FetchTypes.sv
src/FetchAddrGenerateStage.sv
src/FetchAddrTranslateStage.sv
src/Tlb.sv
src/FetchFrontEnd.sv
verif/PageTableMemory.sv
verif/FetchFrontEndTb.sv

//--- verif/FetchFrontEndTb.sv
`timescale 1ns/1ps

module FetchFrontEndTb
    import RvTypes::*;
;
    localparam vaddr_t resetVector = 32'h0000_1000;
    localparam int phaseCycles = 400;
    localparam int cycleLimit = 3 * phaseCycles * 3 / 2;  // three phases plus half again.
    localparam ppn_t rootPpn = 22'h00100;
    localparam ppn_t leafPpn = 22'h00101;  // level-0 table for 0x0040_0000.
    localparam satp_t sv32Satp = {1'b1, 9'b0, rootPpn};
    localparam logic [9:0] ptrFlags = 10'(1 << V);
    localparam logic [9:0] codeFlags = 10'((1 << V) | (1 << R) | (1 << X) | (1 << A));
    localparam logic [9:0] userFlags = codeFlags | 10'(1 << U);
    localparam logic [9:0] noExecFlags = 10'((1 << V) | (1 << R) | (1 << A));
    localparam logic [9:0] noAccessFlags = 10'((1 << V) | (1 << R) | (1 << X));
    localparam logic [9:0] writeOnlyFlags = 10'((1 << V) | (1 << W) | (1 << A));

    logic clk;
    logic rstN;
    logic redirectValid;
    vaddr_t redirectPc;
    logic tlbFlush;
    satp_t satp;
    priv_t priv;
    logic memReadDone;
    word_t memReadValue;
    paddr_t memAddr;
    logic memReadEnable;
    logic fetchValid;
    logic fetchTlbMiss;
    logic fetchTlbFault;
    vaddr_t fetchVaddr;
    paddr_t fetchPaddr;

    integer seed;
    word_t tableCopy [paddr_t];  // model copy of the page tables.
    vaddr_t expPc;  // next fetch the model expects to be accepted.
    priv_t lookPriv;  // priv and satp seen by the last lookup.
    satp_t lookSatp;
    logic passOnly;
    logic walkDeep;  // model walker is reading a level-0 table.
    ppn_t walkTable;  // table named by the last root pte.
    paddr_t walkAddr;  // address of the read in flight.
    int accepted;
    int faults;
    int reads;
    int cycleCount;

    FetchFrontEnd #(
        .resetVector(resetVector),
        .tlbEntries (4)
    ) dut (
        .clk(clk), .rstN(rstN), .redirectValid(redirectValid), .redirectPc(redirectPc),
        .tlbFlush(tlbFlush), .satp(satp), .priv(priv), .memReadDone(memReadDone),
        .memReadValue(memReadValue), .memAddr(memAddr), .memReadEnable(memReadEnable),
        .fetchValid(fetchValid), .fetchTlbMiss(fetchTlbMiss), .fetchTlbFault(fetchTlbFault),
        .fetchVaddr(fetchVaddr), .fetchPaddr(fetchPaddr)
    );

    PageTableMemory pageTables (
        .clk(clk), .rstN(rstN), .readEnable(memReadEnable), .addr(memAddr),
        .readDone(memReadDone), .readValue(memReadValue)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // lookup context, cycle limit and walk read count.
    always @(posedge clk) begin
        lookPriv <= priv;
        lookSatp <= satp;
        cycleCount++;
        if (memReadDone) reads++;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("Test failures found");
            $fatal(1);
        end
    end

    task automatic checkValue(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected,
                     $time);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    // one pte into both the model copy and the memory.
    task automatic setPte(input ppn_t tablePpn, input int index, input ppn_t ppn,
                          input logic [9:0] flags);
        paddr_t a;
        a = {tablePpn, 12'(index * 4)};
        tableCopy[a] = {ppn, flags};
        pageTables.writeWord(a, {ppn, flags});
    endtask

    task automatic loadTables();
        setPte(rootPpn, 1, leafPpn, ptrFlags);       // 4 KiB pages at 0x0040_0000.
        setPte(rootPpn, 2, 22'h00C00, codeFlags);    // good superpage.
        setPte(rootPpn, 3, 22'h00C01, codeFlags);    // misaligned superpage.
        setPte(rootPpn, 4, 22'h01000, userFlags);    // user superpage.
        setPte(leafPpn, 0, 22'h00200, codeFlags);
        setPte(leafPpn, 1, 22'h00201, codeFlags);
        setPte(leafPpn, 2, 22'h00202, userFlags);
        setPte(leafPpn, 3, 22'h00203, userFlags);
        setPte(leafPpn, 4, 22'h00204, noExecFlags);
        setPte(leafPpn, 5, 22'h00205, noAccessFlags);
        setPte(leafPpn, 6, 22'h00206, 10'h000);      // invalid.
        setPte(leafPpn, 7, 22'h00207, writeOnlyFlags);
        setPte(leafPpn, 8, 22'h00102, ptrFlags);     // pointer at level 0.
    endtask

    function automatic word_t tableRead(input paddr_t a);
        return tableCopy.exists(a) ? tableCopy[a] : '0;
    endfunction

    // sv32 translation with the fault rules in priority order.
    function automatic void modelTranslate(input vaddr_t va, input priv_t p, input satp_t s,
                                           output logic f, output paddr_t pa);
        word_t pte;
        logic superPage;
        logic leaf;
        f = 1'b0;
        pa = {2'b00, va};  // m-mode or bare.
        if (p != PrivMachine && s[satpModeBit]) begin
            superPage = 1'b1;
            pte = tableRead({s[21:0], va[31:22], 2'b00});
            leaf = pte[R] || pte[X];
            if (pte[V] && !(pte[W] && !pte[R]) && !leaf) begin
                superPage = 1'b0;  // descend to level 0.
                pte = tableRead({pte[31:10], va[21:12], 2'b00});
                leaf = pte[R] || pte[X];
            end
            if (!pte[V] || (pte[W] && !pte[R])) f = 1'b1;
            else if (!leaf) f = 1'b1;
            else if (!pte[X]) f = 1'b1;
            else if (p == PrivUser && !pte[U]) f = 1'b1;
            else if (p == PrivSupervisor && pte[U]) f = 1'b1;
            else if (!pte[A]) f = 1'b1;
            else if (superPage && pte[19:10] != '0) f = 1'b1;
            if (f) pa = '0;
            else if (superPage) pa = {pte[31:20], va[21:0]};
            else pa = {pte[31:10], va[11:0]};
        end
    endfunction

    // page-aligned jump targets in the mapped region.
    function automatic vaddr_t pickTarget();
        int unsigned pick;
        pick = $unsigned($random(seed)) % 12;
        if (pick < 9) return 32'h0040_0000 + (pick << 12);
        else if (pick == 9) return 32'h0080_3000;
        else if (pick == 10) return 32'h00C0_0000;
        else return 32'h0100_0000;
    endfunction

    task automatic checkFetch();
        logic expFault;
        paddr_t expPaddr;
        word_t pte;
        if (passOnly) begin
            checkValue("memReadEnable", memReadEnable, 0);  // no walks without sv32.
            checkValue("fetchTlbMiss", fetchTlbMiss, 0);
        end
        // a finished root read either descends or ends the walk.
        if (memReadDone) begin
            pte = tableRead(walkAddr);
            walkDeep = !walkDeep && pte[V] && !pte[R] && !pte[W] && !pte[X];
            walkTable = pte[31:10];
        end
        // walk reads hit the root table, then the table its pointer names.
        if (memReadEnable) begin
            checkValue("memAddr", memAddr[33:12], walkDeep ? walkTable : satp[21:0]);
            walkAddr = memAddr;
        end
        if (fetchValid && !fetchTlbMiss) begin
            modelTranslate(expPc, lookPriv, lookSatp, expFault, expPaddr);
            checkValue("fetchVaddr", fetchVaddr, expPc);
            checkValue("fetchTlbFault", fetchTlbFault, expFault);
            checkValue("fetchPaddr", fetchPaddr, expPaddr);
            expPc = expPc + 32'd4;
            accepted++;
            if (expFault) faults++;
        end
    endtask

    // check on the falling edge, then drive the next inputs.
    task automatic stepCycle(input logic randomOn, input logic jumpNow, input logic flushNow);
        @(negedge clk);
        checkFetch();
        redirectValid = jumpNow;
        tlbFlush = flushNow;
        if (randomOn && $unsigned($random(seed)) % 12 == 0) redirectValid = 1'b1;
        if (randomOn && $unsigned($random(seed)) % 40 == 0) tlbFlush = 1'b1;
        if (redirectValid) begin
            redirectPc = pickTarget();
            expPc = redirectPc;  // younger pc gets killed.
        end
    endtask

    // park in m-mode until the walker is idle, then flush and jump.
    task automatic changePhase(input priv_t nextPriv, input satp_t nextSatp);
        int quiet;
        quiet = 0;
        priv = PrivMachine;
        while (quiet < 3) begin
            stepCycle(1'b0, 1'b0, 1'b0);
            quiet = memReadEnable ? 0 : quiet + 1;
        end
        priv = nextPriv;
        satp = nextSatp;
        stepCycle(1'b0, 1'b1, 1'b1);
    endtask

    initial begin
        seed = 32'h88e02f0f;
        rstN = 1'b0;
        redirectValid = 1'b0;
        redirectPc = '0;
        tlbFlush = 1'b0;
        satp = sv32Satp;
        priv = PrivMachine;
        expPc = resetVector;
        passOnly = 1'b1;
        walkDeep = 1'b0;
        walkTable = '0;
        walkAddr = '0;
        accepted = 0;
        faults = 0;
        reads = 0;
        cycleCount = 0;
        loadTables();
        repeat (5) @(negedge clk);
        checkValue("fetchValid", fetchValid, 0);
        checkValue("fetchTlbMiss", fetchTlbMiss, 0);
        checkValue("fetchTlbFault", fetchTlbFault, 0);
        checkValue("fetchVaddr", fetchVaddr, 0);
        checkValue("fetchPaddr", fetchPaddr, 0);
        checkValue("memReadEnable", memReadEnable, 0);
        rstN = 1'b1;
        // m-mode, then supervisor in bare mode.
        for (int i = 0; i < phaseCycles; i++) begin
            if (i == phaseCycles / 2) begin
                priv = PrivSupervisor;
                satp = '0;
            end
            stepCycle(i >= 4, 1'b0, 1'b0);  // reset vector goes through first.
        end
        passOnly = 1'b0;
        changePhase(PrivSupervisor, sv32Satp);
        repeat (phaseCycles) stepCycle(1'b1, 1'b0, 1'b0);
        changePhase(PrivUser, sv32Satp);
        repeat (phaseCycles) stepCycle(1'b1, 1'b0, 1'b0);
        if (accepted < 200 || faults == 0 || reads == 0) begin
            $display("too little activity: %0d fetches, %0d faults, %0d walk reads",
                     accepted, faults, reads);
            $display("Test failures found");
            $fatal(1);
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

//--- verif/PageTableMemory.sv
`timescale 1ns/1ps

module PageTableMemory
    import RvTypes::*;
#(
    parameter logic [31:0] seedInit = 32'h88e02f0f
) (
    input  logic   clk,
    input  logic   rstN,
    input  logic   readEnable,
    input  paddr_t addr,
    output logic   readDone,
    output word_t  readValue
);
    word_t words [paddr_t];  // sparse, unwritten words read as zero.
    integer seed;
    logic busy;
    int unsigned waitCycles;  // cycles left before the answer.

    initial begin
        seed = seedInit;
        busy = 1'b0;
        waitCycles = 0;
        readDone = 1'b0;
        readValue = '0;
    end

    // preload from the testbench.
    task automatic writeWord(input paddr_t a, input word_t value);
        words[a] = value;
    endtask

    function automatic word_t readWord(input paddr_t a);
        return words.exists(a) ? words[a] : '0;
    endfunction

    // answers each read after 1 to 4 cycles, outputs change on the falling edge.
    always @(negedge clk) begin
        readDone <= 1'b0;  // done is a one-cycle pulse.
        if (!rstN) begin
            busy <= 1'b0;
        end else if (busy) begin
            if (waitCycles == 0) begin
                readDone <= 1'b1;
                readValue <= readWord(addr);
                busy <= 1'b0;
            end else begin
                waitCycles <= waitCycles - 1;
            end
        end else if (readEnable) begin
            busy <= 1'b1;  // new request, address already steady.
            waitCycles <= $unsigned($random(seed)) % 4;
        end
    end

endmodule

//--- src/FetchFrontEnd.sv
`timescale 1ns/1ps

module FetchFrontEnd
    import RvTypes::*;
#(
    parameter vaddr_t resetVector = 32'h0000_1000,
    parameter int     tlbEntries  = 4
) (
    input  logic   clk,
    input  logic   rstN,
    input  logic   redirectValid,
    input  vaddr_t redirectPc,
    input  logic   tlbFlush,
    input  satp_t  satp,
    input  priv_t  priv,
    input  logic   memReadDone,
    input  word_t  memReadValue,
    output paddr_t memAddr,
    output logic   memReadEnable,
    output logic   fetchValid,
    output logic   fetchTlbMiss,
    output logic   fetchTlbFault,
    output vaddr_t fetchVaddr,
    output paddr_t fetchPaddr
);
    // generate to translate.
    logic   pcValid;
    vaddr_t pcVaddr;
    logic   flush;

    // registered miss already implies valid, so it feeds replay directly.
    FetchAddrGenerateStage #(
        .resetVector(resetVector)
    ) generateStage (
        .clk           (clk),
        .rstN          (rstN),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .missValid     (fetchTlbMiss),
        .missVaddr     (fetchVaddr),
        .pcValid       (pcValid),
        .pcVaddr       (pcVaddr),
        .flush         (flush)
    );

    FetchAddrTranslateStage #(
        .tlbEntries(tlbEntries)
    ) translateStage (
        .clk           (clk),
        .rstN          (rstN),
        .pcValid       (pcValid),
        .pcVaddr       (pcVaddr),
        .flush         (flush),
        .tlbFlush      (tlbFlush),
        .satp          (satp),
        .priv          (priv),
        .memReadDone   (memReadDone),
        .memReadValue  (memReadValue),
        .memAddr       (memAddr),
        .memReadEnable (memReadEnable),
        .valid         (fetchValid),
        .tlbMiss       (fetchTlbMiss),
        .tlbFault      (fetchTlbFault),
        .vaddrOut      (fetchVaddr),
        .paddrOut      (fetchPaddr)
    );

endmodule

//--- src/Tlb.sv
`timescale 1ns/1ps

module Tlb
    import RvTypes::*;
    import FetchTypes::*;
#(
    parameter int tlbEntries = 4
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            enable,
    input  TlbCommand       command,
    input  vaddr_t          vaddr,
    input  MemoryAccessType accessType,
    input  satp_t           satp,
    input  priv_t           priv,
    input  logic            memReadDone,
    input  word_t           memReadValue,
    output logic            done,
    output logic            fault,
    output paddr_t          paddr,
    output paddr_t          memAddr,
    output logic            memReadEnable
);
    localparam int idxBits = (tlbEntries > 1) ? $clog2(tlbEntries) : 1;
    typedef logic [idxBits-1:0] idx_t;

    // entry store.
    logic [tlbEntries-1:0] entryValid;
    vpn_t entryVpn1 [tlbEntries];
    vpn_t entryVpn0 [tlbEntries];  // ignored for superpages.
    logic entrySuper [tlbEntries];
    ppn_t entryPpn [tlbEntries];
    logic entryU [tlbEntries];
    idx_t victim;  // round-robin pointer.

    // walker.
    WalkState walkState;
    vpn_t walkVpn1;
    vpn_t walkVpn0;
    logic walkFault;
    logic walkSuper;
    logic walkU;
    ppn_t walkPpn;

    // faulting walk result waits here for its replay.
    logic heldValid;
    vpn_t heldVpn1;
    vpn_t heldVpn0;

    vpn_t vpn1;
    vpn_t vpn0;
    logic translating;
    logic hit;
    logic hitSuper;
    logic hitU;
    ppn_t hitPpn;
    logic heldHit;
    logic permFault;
    logic lookupMiss;
    logic consume;
    logic startWalk;
    logic pteArrived;
    logic descend;
    logic fill;
    logic holdFault;
    ppn_t ptePpn;
    logic pteInvalid;
    logic pteLeaf;
    logic leafFault;
    logic pteFault;

    assign vpn1 = vaddr[31:22];
    assign vpn0 = vaddr[21:12];
    // m-mode and bare mode pass straight through.
    assign translating = satp[satpModeBit] && (priv != PrivMachine);

    // fully associative match.
    always_comb begin
        hit = 1'b0;
        hitSuper = 1'b0;
        hitU = 1'b0;
        hitPpn = '0;
        for (int i = 0; i < tlbEntries; i++) begin
            if (entryValid[i] && entryVpn1[i] == vpn1
                    && (entrySuper[i] || entryVpn0[i] == vpn0)) begin
                hit = 1'b1;
                hitSuper = entrySuper[i];
                hitU = entryU[i];
                hitPpn = entryPpn[i];
            end
        end
    end

    assign heldHit = heldValid && heldVpn1 == vpn1 && heldVpn0 == vpn0;
    // u bit checked against current privilege.
    assign permFault = (priv == PrivUser && !hitU) || (priv == PrivSupervisor && hitU);

    // lookup result, all in the same cycle.
    always_comb begin
        done = 1'b0;
        fault = 1'b0;
        paddr = '0;  // faults report zero.
        if (enable) begin
            if (!translating) begin
                done = 1'b1;
                paddr = {2'b00, vaddr};
            end else if (hit) begin
                done = 1'b1;
                fault = permFault;
                if (!permFault) begin
                    paddr = hitSuper ? {hitPpn[21:10], vaddr[21:0]}
                                     : {hitPpn, vaddr[pageOffsetBits-1:0]};
                end
            end else if (heldHit) begin
                done = 1'b1;  // walk already said this page faults.
                fault = 1'b1;
            end
        end
    end

    assign lookupMiss = enable && (command == TlbCommand_Translate) && !done;
    assign consume = enable && (command == TlbCommand_Translate) && translating
                     && !hit && heldHit;

    // pte decode and fault rules.
    always_comb begin
        ptePpn = memReadValue[31:10];
        pteInvalid = !memReadValue[V] || (memReadValue[W] && !memReadValue[R]);
        pteLeaf = memReadValue[R] || memReadValue[X];
        case (accessType)
            MemoryAccessType_Load:  leafFault = !memReadValue[R];
            MemoryAccessType_Store: leafFault = !memReadValue[W];
            default:                leafFault = !memReadValue[X];
        endcase
        if (priv == PrivUser && !memReadValue[U]) begin
            leafFault = 1'b1;  // supervisor page from user.
        end
        if (priv == PrivSupervisor && memReadValue[U]) begin
            leafFault = 1'b1;  // user page from supervisor.
        end
        if (!memReadValue[A]) begin
            leafFault = 1'b1;  // no a-bit update here.
        end
        if (walkState == WalkState_Level1) begin
            // superpage must have its low ppn bits clear.
            pteFault = pteInvalid
                || (pteLeaf && (leafFault || ptePpn[9:0] != '0));
        end else begin
            pteFault = pteInvalid || !pteLeaf || leafFault;
        end
    end

    // walker strobes.
    assign startWalk = (walkState == WalkState_Idle) && lookupMiss;
    assign memReadEnable = (walkState == WalkState_Level1) || (walkState == WalkState_Level0);
    assign pteArrived = memReadEnable && memReadDone;
    assign descend = (walkState == WalkState_Level1) && memReadDone && !pteInvalid && !pteLeaf;
    assign fill = (walkState == WalkState_Result) && !walkFault;
    assign holdFault = (walkState == WalkState_Result) && walkFault;

    // control state.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            walkState <= WalkState_Idle;
            entryValid <= '0;
            victim <= '0;
            heldValid <= 1'b0;
        end else begin
            case (walkState)
                WalkState_Idle: begin
                    if (startWalk) walkState <= WalkState_Level1;
                end
                WalkState_Level1: begin
                    if (memReadDone) begin
                        walkState <= descend ? WalkState_Level0 : WalkState_Result;
                    end
                end
                WalkState_Level0: begin
                    if (memReadDone) walkState <= WalkState_Result;
                end
                default: walkState <= WalkState_Idle;  // result lasts one cycle.
            endcase
            if (command == TlbCommand_Flush) begin
                entryValid <= '0;
                heldValid <= 1'b0;
            end else if (consume) begin
                heldValid <= 1'b0;  // fault reported once.
            end
            // an in-flight walk still lands after a flush.
            if (fill) begin
                entryValid[victim] <= 1'b1;
                victim <= (victim == idx_t'(tlbEntries - 1)) ? '0 : victim + 1'b1;
            end
            if (holdFault) heldValid <= 1'b1;
        end
    end

    // walk and entry payload.
    always_ff @(posedge clk) begin
        if (startWalk) begin
            walkVpn1 <= vpn1;
            walkVpn0 <= vpn0;
            memAddr <= {satp[21:0], vpn1, 2'b00};  // root pte address.
        end
        if (descend) memAddr <= {ptePpn, walkVpn0, 2'b00};
        if (pteArrived) begin
            walkFault <= pteFault;
            walkSuper <= (walkState == WalkState_Level1);
            walkPpn <= ptePpn;
            walkU <= memReadValue[U];
        end
        if (fill) begin
            entryVpn1[victim] <= walkVpn1;
            entryVpn0[victim] <= walkVpn0;
            entrySuper[victim] <= walkSuper;
            entryPpn[victim] <= walkPpn;
            entryU[victim] <= walkU;
        end
        if (holdFault) begin
            heldVpn1 <= walkVpn1;
            heldVpn0 <= walkVpn0;
        end
    end

    // request held steady until the memory answers.
    assert property (@(posedge clk) disable iff (!rstN)
        memReadEnable && !memReadDone |=> memReadEnable && $stable(memAddr));

endmodule

//--- src/FetchAddrTranslateStage.sv
`timescale 1ns/1ps

module FetchAddrTranslateStage
    import RvTypes::*;
    import FetchTypes::*;
#(
    parameter int tlbEntries = 4
) (
    input  logic   clk,
    input  logic   rstN,
    input  logic   pcValid,
    input  vaddr_t pcVaddr,
    input  logic   flush,
    input  logic   tlbFlush,
    input  satp_t  satp,
    input  priv_t  priv,
    input  logic   memReadDone,
    input  word_t  memReadValue,
    output paddr_t memAddr,
    output logic   memReadEnable,
    output logic   valid,
    output logic   tlbMiss,
    output logic   tlbFault,
    output vaddr_t vaddrOut,
    output paddr_t paddrOut
);
    logic      enable;
    TlbCommand command;
    logic      done;
    logic      fault;
    paddr_t    paddr;

    assign enable = pcValid;  // look up only real pcs.
    assign command = tlbFlush ? TlbCommand_Flush : TlbCommand_Translate;

    Tlb #(
        .tlbEntries(tlbEntries)
    ) tlb (
        .clk           (clk),
        .rstN          (rstN),
        .enable        (enable),
        .command       (command),
        .vaddr         (pcVaddr),
        .accessType    (MemoryAccessType_Instruction),
        .satp          (satp),
        .priv          (priv),
        .memReadDone   (memReadDone),
        .memReadValue  (memReadValue),
        .done          (done),
        .fault         (fault),
        .paddr         (paddr),
        .memAddr       (memAddr),
        .memReadEnable (memReadEnable)
    );

    // stage register, flush kills the younger pc.
    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            valid    <= 1'b0;
            tlbFault <= 1'b0;
            tlbMiss  <= 1'b0;
            vaddrOut <= '0;
            paddrOut <= '0;
        end else begin
            valid    <= pcValid;
            tlbFault <= fault;
            tlbMiss  <= pcValid && !done;  // miss only counts for a valid pc.
            vaddrOut <= pcVaddr;
            paddrOut <= paddr;
        end
    end

    // a fault is a finished lookup, never a miss.
    assert property (@(posedge clk) disable iff (!rstN)
        tlbFault |-> valid && !tlbMiss);

endmodule

//--- src/FetchAddrGenerateStage.sv
`timescale 1ns/1ps

module FetchAddrGenerateStage
    import RvTypes::*;
#(
    parameter vaddr_t resetVector = 32'h0000_1000
) (
    input  logic   clk,
    input  logic   rstN,
    input  logic   redirectValid,
    input  vaddr_t redirectPc,
    input  logic   missValid,  // registered valid and miss from translate.
    input  vaddr_t missVaddr,
    output logic   pcValid,
    output vaddr_t pcVaddr,
    output logic   flush
);
    vaddr_t nextPc;

    // next pc select, redirect beats replay beats sequential.
    always_comb begin
        nextPc = pcVaddr + 32'd4;  // default sequential step.
        flush = 1'b0;
        if (redirectValid) begin
            nextPc = redirectPc;
            flush = 1'b1;  // younger pc in translate is wrong path.
        end else if (missValid) begin
            // replay the missed pc, the one behind it gets killed.
            nextPc = missVaddr;
            flush = 1'b1;
        end else if (!pcValid) begin
            nextPc = pcVaddr;  // hold reset vector until it is issued.
        end
    end

    // pc register.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pcValid <= 1'b0;
            pcVaddr <= resetVector;
        end else begin
            pcValid <= 1'b1;  // issues every cycle once out of reset.
            pcVaddr <= nextPc;
        end
    end

    // a redirect must always kill what is already in translate.
    assert property (@(posedge clk) disable iff (!rstN)
        redirectValid |-> flush);

endmodule

//--- src/FetchTypes.sv
package FetchTypes;

    // what the tlb is asked to do this cycle.
    typedef enum logic {
        TlbCommand_Translate,
        TlbCommand_Flush      // drops every entry and the held fault.
    } TlbCommand;

    // kind of access being translated.
    // fetch only ever sends instruction.
    typedef enum logic [1:0] {
        MemoryAccessType_Instruction,
        MemoryAccessType_Load,
        MemoryAccessType_Store
    } MemoryAccessType;

    // page-table walker states.
    typedef enum logic [1:0] {
        WalkState_Idle,
        WalkState_Level1,  // reading the root table.
        WalkState_Level0,  // reading the leaf table.
        WalkState_Result   // filling an entry or holding a fault.
    } WalkState;

endpackage

//--- src/RvTypes.sv
package RvTypes;

    // address and data widths.
    typedef logic [31:0] vaddr_t;  // virtual address.
    typedef logic [33:0] paddr_t;  // sv32 physical address.
    typedef logic [31:0] word_t;   // one memory word.

    // page number fields.
    typedef logic [9:0]  vpn_t;    // one vpn slice per level.
    typedef logic [21:0] ppn_t;    // full physical page number.

    // satp holds mode in bit 31, root ppn in the low 22 bits.
    typedef logic [31:0] satp_t;
    localparam int satpModeBit = 31;

    // privilege encodings as in mstatus.mpp.
    typedef logic [1:0] priv_t;
    localparam priv_t PrivUser       = 2'b00;
    localparam priv_t PrivSupervisor = 2'b01;
    localparam priv_t PrivMachine    = 2'b11;

    // pte flag bit positions.
    localparam int V = 0;  // valid.
    localparam int R = 1;  // readable.
    localparam int W = 2;  // writable.
    localparam int X = 3;  // executable.
    localparam int U = 4;  // user page.
    localparam int A = 6;  // accessed.

    // 4 KiB base page.
    localparam int pageOffsetBits = 12;

endpackage
